/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_rv_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := sim failed
PASS_MSG  := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+testbench
src/rv_core_pkg.sv
src/rv_register_file.sv
src/rv_fetch_stage.sv
src/rv_decode_stage.sv
src/rv_execute_stage.sv
src/rv_core.sv
testbench/tb_rv_core.sv

/* src/rv_core.sv */
// RV32I core top level
// Fetch, decode and execute stages joined to the instruction and data buses

module rv_core (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic [rv_core_pkg::XLEN-1:0] boot_addr_i,
  // Instruction bus
  output logic                         instr_req_o,
  output logic [rv_core_pkg::XLEN-1:0] instr_addr_o,
  input  logic                         instr_gnt_i,
  input  logic                         instr_rvalid_i,
  input  logic [rv_core_pkg::XLEN-1:0] instr_rdata_i,
  // Data bus, stores only
  output logic                         data_req_o,
  output logic                         data_we_o,
  output logic [rv_core_pkg::XLEN-1:0] data_addr_o,
  output logic [rv_core_pkg::XLEN-1:0] data_wdata_o,
  input  logic                         data_gnt_i
);

  rv_core_pkg::instr_req_t  instr_req;
  rv_core_pkg::if_id_pipe_t if_id_pipe;
  rv_core_pkg::id_ex_pipe_t id_ex_pipe;
  rv_core_pkg::rf_wr_t      rf_wr;
  rv_core_pkg::data_req_t   data_req;
  logic                     id_ready;
  logic                     ex_ready;

  // Flat bus ports
  assign instr_req_o  = instr_req.req;
  assign instr_addr_o = instr_req.addr;
  assign data_req_o   = data_req.req;
  // Every data request is a store
  assign data_we_o    = data_req.req;
  assign data_addr_o  = data_req.addr;
  assign data_wdata_o = data_req.wdata;

  rv_fetch_stage rv_fetch_stage_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .id_ready_i     (id_ready),
    .if_id_pipe_o   (if_id_pipe)
  );

  // Writeback feeds both the register file and forwarding
  rv_decode_stage rv_decode_stage_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .if_id_pipe_i (if_id_pipe),
    .id_ready_o   (id_ready),
    .ex_ready_i   (ex_ready),
    .ex_wr_i      (rf_wr),
    .id_ex_pipe_o (id_ex_pipe),
    .wr_i         (rf_wr)
  );

  rv_execute_stage rv_execute_stage_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .id_ex_pipe_i (id_ex_pipe),
    .ex_ready_o   (ex_ready),
    .rf_wr_o      (rf_wr),
    .data_req_o   (data_req),
    .data_gnt_i   (data_gnt_i)
  );

endmodule

/* src/rv_core_pkg.sv */
// RV32I core package
// Widths, opcode and function codes, instruction views and pipeline structs
// shared by every stage of the three stage core

package rv_core_pkg;

  ////////////////////////////////////////
  // Widths and reset values
  ////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam logic [XLEN-1:0] RESET_WORD = 32'h0000_0000;

  // Major opcodes kept by this core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // funct3 codes, ALU group
  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;
  // Word store only
  localparam logic [2:0] FUNCT3_SW      = 3'b010;
  // Selects SUB and SRA
  localparam logic [6:0] FUNCT7_ALT     = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  ////////////////////////////////////////
  // Instruction word views
  ////////////////////////////////////////

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    logic [6:0]            opcode;
  } s_type_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } u_type_t;

  // Same 32 bits, read by format
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    u_type_t u;
  } rv_instr_u;

  ////////////////////////////////////////
  // Pipeline and bus structs
  ////////////////////////////////////////

  typedef struct packed {
    logic      valid;
    rv_instr_u instr;
  } if_id_pipe_t;

  typedef struct packed {
    logic                  valid;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       store_data;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rf_we;
    logic                  store;
  } id_ex_pipe_t;

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } rf_wr_t;

  typedef struct packed {
    logic            req;
    logic [XLEN-1:0] addr;
  } instr_req_t;

  // Stores only, so write enable is implied by req
  typedef struct packed {
    logic            req;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } data_req_t;

endpackage

/* src/rv_decode_stage.sv */
// Decode stage
// Decodes the fetched word, reads operands with forwarding from execute
// and loads the decode/execute register

module rv_decode_stage (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  rv_core_pkg::if_id_pipe_t if_id_pipe_i,
  output logic                     id_ready_o,
  input  logic                     ex_ready_i,
  input  rv_core_pkg::rf_wr_t      ex_wr_i,
  output rv_core_pkg::id_ex_pipe_t id_ex_pipe_o,
  input  rv_core_pkg::rf_wr_t      wr_i
);

  rv_core_pkg::rv_instr_u       instr;
  logic [rv_core_pkg::XLEN-1:0] rf_rdata_a;
  logic [rv_core_pkg::XLEN-1:0] rf_rdata_b;
  logic [rv_core_pkg::XLEN-1:0] rs1_val;
  logic [rv_core_pkg::XLEN-1:0] rs2_val;
  logic                         legal;
  rv_core_pkg::id_ex_pipe_t     dec;
  rv_core_pkg::id_ex_pipe_t     id_ex_q;

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic rv_core_pkg::alu_op_e funct3_to_alu(input logic [2:0] f3, input logic alt);
    rv_core_pkg::alu_op_e op;
    case (f3)
      rv_core_pkg::FUNCT3_ADD_SUB: op = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      rv_core_pkg::FUNCT3_SLL:     op = rv_core_pkg::ALU_SLL;
      rv_core_pkg::FUNCT3_SLT:     op = rv_core_pkg::ALU_SLT;
      rv_core_pkg::FUNCT3_SLTU:    op = rv_core_pkg::ALU_SLTU;
      rv_core_pkg::FUNCT3_XOR:     op = rv_core_pkg::ALU_XOR;
      rv_core_pkg::FUNCT3_SRL_SRA: op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      rv_core_pkg::FUNCT3_OR:      op = rv_core_pkg::ALU_OR;
      default:                     op = rv_core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign instr = if_id_pipe_i.instr;

  // Register read, rs fields sit at the same place in every format
  rv_register_file rv_register_file_inst (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .raddr_a_i (instr.r.rs1),
    .raddr_b_i (instr.r.rs2),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .wr_i      (wr_i)
  );

  // Forward the result retiring in execute this cycle
  assign rs1_val = (ex_wr_i.we && (ex_wr_i.addr == instr.r.rs1) && (instr.r.rs1 != '0))
                   ? ex_wr_i.data : rf_rdata_a;
  assign rs2_val = (ex_wr_i.we && (ex_wr_i.addr == instr.r.rs2) && (instr.r.rs2 != '0))
                   ? ex_wr_i.data : rf_rdata_b;

  ////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////

  always_comb begin
    dec            = '0;
    legal          = 1'b0;
    dec.op_a       = rs1_val;
    dec.store_data = rs2_val;
    dec.rd         = instr.r.rd;
    case (instr.r.opcode)
      rv_core_pkg::OPC_OP: begin
        // ALT only valid on ADD/SUB and SRL/SRA
        legal = (instr.r.funct7 == 7'b0) ||
                ((instr.r.funct7 == rv_core_pkg::FUNCT7_ALT) &&
                 ((instr.r.funct3 == rv_core_pkg::FUNCT3_ADD_SUB) ||
                  (instr.r.funct3 == rv_core_pkg::FUNCT3_SRL_SRA)));
        dec.alu_op = funct3_to_alu(instr.r.funct3, instr.r.funct7 == rv_core_pkg::FUNCT7_ALT);
        dec.op_b   = rs2_val;
        dec.rf_we  = 1'b1;
      end
      rv_core_pkg::OPC_OP_IMM: begin
        // Shift forms carry funct7 in imm[11:5]
        case (instr.i.funct3)
          rv_core_pkg::FUNCT3_SLL:     legal = (instr.r.funct7 == 7'b0);
          rv_core_pkg::FUNCT3_SRL_SRA: legal = (instr.r.funct7 == 7'b0) ||
                                               (instr.r.funct7 == rv_core_pkg::FUNCT7_ALT);
          default:                     legal = 1'b1;
        endcase
        dec.alu_op = funct3_to_alu(instr.i.funct3,
                                   (instr.i.funct3 == rv_core_pkg::FUNCT3_SRL_SRA) &&
                                   (instr.r.funct7 == rv_core_pkg::FUNCT7_ALT));
        dec.op_b   = {{20{instr.i.imm[11]}}, instr.i.imm};
        dec.rf_we  = 1'b1;
      end
      rv_core_pkg::OPC_LUI: begin
        legal      = 1'b1;
        dec.alu_op = rv_core_pkg::ALU_PASS_B;
        dec.op_b   = {instr.u.imm, 12'b0};
        dec.rf_we  = 1'b1;
      end
      rv_core_pkg::OPC_STORE: begin
        // SW only, address is rs1 plus S immediate
        legal      = (instr.s.funct3 == rv_core_pkg::FUNCT3_SW);
        dec.alu_op = rv_core_pkg::ALU_ADD;
        dec.op_b   = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
        dec.store  = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    // Unknown words leave as bubbles
    dec.valid = if_id_pipe_i.valid && legal;
  end

  // Execute never stalls on us, decode stalls on execute
  assign id_ready_o = ex_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_ex_q <= '0;
    end else if (ex_ready_i) begin
      id_ex_q <= dec;
    end
  end

  assign id_ex_pipe_o = id_ex_q;

  a_store_no_rf_write : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    id_ex_pipe_o.valid && id_ex_pipe_o.store |-> !id_ex_pipe_o.rf_we
  );

endmodule

/* src/rv_execute_stage.sv */
// Execute stage
// ALU, register writeback and word store requests on the data bus,
// stores hold the pipe until granted

module rv_execute_stage (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  rv_core_pkg::id_ex_pipe_t id_ex_pipe_i,
  output logic                     ex_ready_o,
  output rv_core_pkg::rf_wr_t      rf_wr_o,
  output rv_core_pkg::data_req_t   data_req_o,
  input  logic                     data_gnt_i
);

  logic [rv_core_pkg::XLEN-1:0] op_a;
  logic [rv_core_pkg::XLEN-1:0] op_b;
  logic [4:0]                   shamt;
  logic [rv_core_pkg::XLEN-1:0] alu_result;
  logic                         store_pending;

  assign op_a  = id_ex_pipe_i.op_a;
  assign op_b  = id_ex_pipe_i.op_b;
  // Shift amount from low bits, reg or imm
  assign shamt = op_b[4:0];

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    case (id_ex_pipe_i.alu_op)
      rv_core_pkg::ALU_ADD:    alu_result = op_a + op_b;
      rv_core_pkg::ALU_SUB:    alu_result = op_a - op_b;
      rv_core_pkg::ALU_SLL:    alu_result = op_a << shamt;
      // Set-less-than, signed then unsigned
      rv_core_pkg::ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_core_pkg::ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      rv_core_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      rv_core_pkg::ALU_SRL:    alu_result = op_a >> shamt;
      rv_core_pkg::ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
      rv_core_pkg::ALU_OR:     alu_result = op_a | op_b;
      rv_core_pkg::ALU_AND:    alu_result = op_a & op_b;
      // LUI, immediate already shifted in decode
      rv_core_pkg::ALU_PASS_B: alu_result = op_b;
      default:                 alu_result = '0;
    endcase
  end

  ////////////////////////////////////////
  // Writeback
  ////////////////////////////////////////

  // ALU ops retire in their execute cycle
  assign rf_wr_o.we   = id_ex_pipe_i.valid && id_ex_pipe_i.rf_we;
  assign rf_wr_o.addr = id_ex_pipe_i.rd;
  assign rf_wr_o.data = alu_result;

  ////////////////////////////////////////
  // Store path
  ////////////////////////////////////////

  assign store_pending = id_ex_pipe_i.valid && id_ex_pipe_i.store;

  // Address from the ALU adder
  assign data_req_o.req   = store_pending;
  assign data_req_o.addr  = alu_result;
  assign data_req_o.wdata = id_ex_pipe_i.store_data;

  // Store retires on grant, no wait for a response
  assign ex_ready_o = !store_pending || data_gnt_i;

  // Held by the decode/execute register while stalled
  a_store_req_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    data_req_o.req && !data_gnt_i |=>
      data_req_o.req && $stable(data_req_o.addr) && $stable(data_req_o.wdata)
  );

endmodule

/* src/rv_fetch_stage.sv */
// Fetch stage
// Issues instruction bus requests, one at a time, and holds the
// returned word until decode takes it

module rv_fetch_stage (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic [rv_core_pkg::XLEN-1:0] boot_addr_i,
  output rv_core_pkg::instr_req_t      instr_req_o,
  input  logic                         instr_gnt_i,
  input  logic                         instr_rvalid_i,
  input  logic [rv_core_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                         id_ready_i,
  output rv_core_pkg::if_id_pipe_t     if_id_pipe_o
);

  // PC of the next request, valid once booted
  logic [rv_core_pkg::XLEN-1:0] pc_q;
  logic                         booted_q;
  // Granted, read-valid still due
  logic                         outstanding_q;
  logic [rv_core_pkg::XLEN-1:0] fetch_addr;
  logic                         fetch_req;
  rv_core_pkg::if_id_pipe_t     if_id_q;

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // First request goes to the boot address
  assign fetch_addr = booted_q ? pc_q : boot_addr_i;

  // Only request when the fetch register will be free at read-valid
  // Once raised, the register stays empty until the answer, so req holds
  assign fetch_req = !outstanding_q && (!if_id_q.valid || id_ready_i);

  assign instr_req_o.req  = fetch_req;
  assign instr_req_o.addr = fetch_addr;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q          <= rv_core_pkg::RESET_WORD;
      booted_q      <= 1'b0;
      outstanding_q <= 1'b0;
    end else begin
      if (fetch_req && instr_gnt_i) begin
        // No branches, PC only steps by a word
        pc_q          <= fetch_addr + rv_core_pkg::XLEN'(4);
        booted_q      <= 1'b1;
        outstanding_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Fetch register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      if_id_q <= '0;
    end else begin
      if (instr_rvalid_i) begin
        if_id_q.valid <= 1'b1;
        if_id_q.instr <= instr_rdata_i;
      end else if (id_ready_i) begin
        // Word consumed by decode
        if_id_q.valid <= 1'b0;
      end
    end
  end

  assign if_id_pipe_o = if_id_q;

  // Pending request keeps its address until grant
  a_instr_addr_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    instr_req_o.req && !instr_gnt_i |=> instr_req_o.req && $stable(instr_req_o.addr)
  );

endmodule

/* src/rv_register_file.sv */
// Integer register file
// Registers x1 to x31, two read ports and one write port, x0 reads zero

module rv_register_file (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_b_o,
  input  rv_core_pkg::rf_wr_t                wr_i
);

  // No storage behind x0
  logic [rv_core_pkg::XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= rv_core_pkg::RESET_WORD;
      end
    end else begin
      // Writes to x0 dropped
      if (wr_i.we && (wr_i.addr != '0)) begin
        regs_q[wr_i.addr] <= wr_i.data;
      end
    end
  end

  // Combinational read, same cycle writes come in through forwarding
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* testbench/tb_rv_model.svh */
// Program generator and reference model for the RV32I core testbench
// Builds a random program into instruction memory and runs it on a
// shadow register file, queueing the address and data of every store

`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// Major opcodes straight from the ISA
localparam logic [6:0]  OPC_R    = 7'h33;
localparam logic [6:0]  OPC_I    = 7'h13;
localparam logic [6:0]  OPC_LUI  = 7'h37;
localparam logic [6:0]  OPC_SW   = 7'h23;
// ADDI x0, x0, 0 past the end of the program
localparam logic [31:0] NOP_WORD = 32'h0000_0013;
localparam int          PROG_LEN = 200;

// Program kinds
localparam int MODE_NONE = 0;
localparam int MODE_REG  = 1;
localparam int MODE_IMM  = 2;
localparam int MODE_DEP  = 3;
localparam int MODE_MIX  = 4;

logic [31:0] imem [logic [31:0]];
logic [31:0] shadow [32];
logic [31:0] exp_addr_q [$];
logic [31:0] exp_data_q [$];
logic [31:0] gen_pc;
int          gen_count;

//////////////////////////////////////////
// Reference model
//////////////////////////////////////////

// ALU by funct3, alt is the SUB/SRA bit
function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  logic [31:0] sign_fill;
  sign_fill = a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0;
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return alt ? ((a >> b[4:0]) | sign_fill) : (a >> b[4:0]);
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

// One word on the shadow registers
task automatic model_exec(input logic [31:0] w);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic        wr;
  a   = shadow[w[19:15]];
  b   = shadow[w[24:20]];
  res = '0;
  wr  = 1'b1;
  case (w[6:0])
    OPC_R:   res = ref_alu(w[14:12], w[30], a, b);
    // Bit 30 only means SRAI in the I format
    OPC_I:   res = ref_alu(w[14:12], w[30] && (w[14:12] == 3'd5), a,
                           {{20{w[31]}}, w[31:20]});
    OPC_LUI: res = {w[31:12], 12'h000};
    default: begin
      wr = 1'b0;
      exp_addr_q.push_back(a + {{20{w[31]}}, w[31:25], w[11:7]});
      exp_data_q.push_back(b);
    end
  endcase
  if (wr && (w[11:7] != 5'd0)) begin
    shadow[w[11:7]] = res;
  end
endtask

task automatic emit(input logic [31:0] w);
  imem[gen_pc] = w;
  model_exec(w);
  gen_pc    = gen_pc + 32'd4;
  gen_count = gen_count + 1;
endtask

//////////////////////////////////////////
// Random instructions
//////////////////////////////////////////

function automatic logic [4:0] rand_nz();
  return 5'($urandom_range(31, 1));
endfunction

function automatic logic [31:0] rand_reg_op(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
  logic [2:0] f3;
  logic       alt;
  f3  = 3'($urandom_range(7, 0));
  // SUB and SRA about half the time
  alt = ((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom_range(1, 0) == 1);
  return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_R};
endfunction

// I-type ALU op, sometimes LUI
function automatic logic [31:0] rand_imm_op(input logic [4:0] rd, input logic [4:0] rs1);
  logic [2:0]  f3;
  logic [11:0] imm;
  f3  = 3'($urandom_range(7, 0));
  imm = 12'($urandom);
  if (f3 == 3'd1) begin
    imm[11:5] = 7'h00;
  end
  // SRLI or SRAI
  if (f3 == 3'd5) begin
    imm[11:5] = {1'b0, imm[10], 5'b0};
  end
  if ($urandom_range(7, 0) == 0) begin
    return {20'($urandom), rd, OPC_LUI};
  end
  return {imm, rs1, f3, rd, OPC_I};
endfunction

function automatic logic [31:0] sw_word(input logic [4:0] data_reg, input logic [4:0] base_reg);
  logic [11:0] imm;
  imm = 12'($urandom);
  return {imm[11:5], data_reg, base_reg, 3'b010, imm[4:0], OPC_SW};
endfunction

//////////////////////////////////////////
// Program builder
//////////////////////////////////////////

task automatic gen_program(input int mode, input logic [31:0] base);
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] prev;
  logic [1:0] pick;
  imem.delete();
  exp_addr_q.delete();
  exp_data_q.delete();
  for (int i = 0; i < 32; i++) begin
    shadow[i] = '0;
  end
  gen_pc    = base;
  gen_count = 0;
  prev      = 5'd1;
  if (mode == MODE_NONE) begin
    return;
  end
  // Random values into eight registers first
  repeat (8) begin
    rd = rand_nz();
    emit({20'($urandom), rd, OPC_LUI});
    emit({12'($urandom), rd, 3'd0, rd, OPC_I});
    prev = rd;
  end
  while (gen_count < PROG_LEN) begin
    rd   = rand_nz();
    rs1  = rand_nz();
    rs2  = rand_nz();
    pick = 2'($urandom_range(3, 0));
    case (mode)
      MODE_REG: begin
        emit(rand_reg_op(rd, rs1, rs2));
        emit(sw_word(rd, rs1));
      end
      MODE_IMM: begin
        emit(rand_imm_op(rd, rs1));
        emit(sw_word(rd, rs2));
      end
      MODE_DEP: begin
        // Occasional x0 target, its reader must see zero
        if (pick == 2'd0) begin
          rd = 5'd0;
        end
        if (pick[0]) begin
          emit(rand_reg_op(rd, prev, pick[1] ? prev : rs2));
        end else begin
          emit(rand_imm_op(rd, prev));
        end
        if (pick != 2'd3) begin
          emit(sw_word(rd, prev));
        end
        prev = rd;
      end
      default: begin
        if (pick == 2'd0) begin
          emit(rand_reg_op(rd, rs1, rs2));
        end else if (pick == 2'd1) begin
          emit(rand_imm_op(rd, rs1));
        end else begin
          emit(sw_word(rs2, rs1));
        end
      end
    endcase
  end
endtask

`endif

/* testbench/tb_rv_core.sv */
// Testbench for the RV32I core
// Random programs served over the instruction bus, stores on the data
// bus checked against the reference model, with random bus delays

module tb_rv_core;

  `include "tb_rv_model.svh"

  localparam int unsigned RAND_SEED    = 58316;
  localparam int          NUM_TESTS    = 5;
  localparam int          DRAIN_CYCLES = 20;
  // Ten cycles per instruction over all tests
  localparam int          CYCLE_LIMIT  = NUM_TESTS * PROG_LEN * 10;

  logic        clk;
  logic        arst_n;
  logic [31:0] boot_addr;
  logic        instr_req;
  logic [31:0] instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_rdata;
  logic        data_req;
  logic        data_we;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic        data_gnt;

  // Responder delay ranges set per test
  int          igrant_min;
  int          igrant_max;
  int          ivalid_min;
  int          ivalid_max;
  int          dgrant_max;
  // Responder state
  int          igrant_wait;
  int          ivalid_wait;
  int          dgrant_wait;
  logic [31:0] pend_addr;
  logic [31:0] exp_addr;
  logic [31:0] exp_data;

  int          cycle_count;
  int          test_errors;
  int          stores_seen;
  int          error_count;
  int          tests_run;
  int          tests_failed;

  rv_core rv_core_inst (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .boot_addr_i    (boot_addr),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .data_req_o     (data_req),
    .data_we_o      (data_we),
    .data_addr_o    (data_addr),
    .data_wdata_o   (data_wdata),
    .data_gnt_i     (data_gnt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////
  // Instruction bus responder
  //////////////////////////////////////////

  always @(posedge clk) begin
    if (!arst_n) begin
      instr_gnt    <= 1'b0;
      instr_rvalid <= 1'b0;
      igrant_wait  = 0;
      ivalid_wait  = 0;
    end else begin
      instr_rvalid <= 1'b0;
      if (instr_req && instr_gnt) begin
        pend_addr   = instr_addr;
        ivalid_wait = $urandom_range(ivalid_max, ivalid_min);
        igrant_wait = $urandom_range(igrant_max, igrant_min);
        // Zero delay means grant already up for the next request
        instr_gnt  <= (igrant_wait == 0);
      end else if (instr_req) begin
        if (igrant_wait <= 1) begin
          instr_gnt <= 1'b1;
        end else begin
          igrant_wait--;
        end
      end
      // Read-valid d cycles after the grant cycle
      if (ivalid_wait > 0) begin
        ivalid_wait--;
        if (ivalid_wait == 0) begin
          instr_rvalid <= 1'b1;
          instr_rdata  <= imem.exists(pend_addr) ? imem[pend_addr] : NOP_WORD;
        end
      end
    end
  end

  //////////////////////////////////////////
  // Data bus responder and store checks
  //////////////////////////////////////////

  always @(posedge clk) begin
    if (!arst_n) begin
      data_gnt    <= 1'b0;
      dgrant_wait = 0;
    end else if (data_req && data_gnt) begin
      stores_seen++;
      if (data_we !== 1'b1) begin
        $display("** Error data_we_o: expected 1, actual %h", data_we);
        test_errors++;
      end
      if (exp_addr_q.size() == 0) begin
        $display("Store to %08h arrived with no store left in the model", data_addr);
        test_errors++;
      end else begin
        exp_addr = exp_addr_q.pop_front();
        exp_data = exp_data_q.pop_front();
        if (data_addr !== exp_addr) begin
          $display("** Error data_addr_o: expected %08h, actual %08h", exp_addr, data_addr);
          test_errors++;
        end
        if (data_wdata !== exp_data) begin
          $display("** Error data_wdata_o: expected %08h, actual %08h", exp_data, data_wdata);
          test_errors++;
        end
      end
      dgrant_wait = $urandom_range(dgrant_max, 0);
      data_gnt   <= (dgrant_wait == 0);
    end else if (data_req) begin
      if (dgrant_wait <= 1) begin
        data_gnt <= 1'b1;
      end else begin
        dgrant_wait--;
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d stores never arrived",
               CYCLE_LIMIT, exp_addr_q.size());
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////

  task automatic run_test(input string name, input int mode, input int ig_min,
                          input int ig_max, input int iv_min, input int iv_max,
                          input int dg_max);
    logic [31:0] boot;
    arst_n <= 1'b0;
    @(posedge clk);
    igrant_min  = ig_min;
    igrant_max  = ig_max;
    ivalid_min  = iv_min;
    ivalid_max  = iv_max;
    dgrant_max  = dg_max;
    test_errors = 0;
    stores_seen = 0;
    boot        = $urandom & 32'hFFFF_FFFC;
    gen_program(mode, boot);
    boot_addr <= boot;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    // First cycle out of reset
    @(posedge clk);
    if (instr_req !== 1'b1) begin
      $display("** Error instr_req_o: expected 1, actual %h", instr_req);
      test_errors++;
    end
    if (instr_addr !== boot) begin
      $display("** Error instr_addr_o: expected %08h, actual %08h", boot, instr_addr);
      test_errors++;
    end
    if (data_req !== 1'b0) begin
      $display("** Error data_req_o: expected 0, actual %h", data_req);
      test_errors++;
    end
    // Wait for every modelled store and stay quiet to catch repeats
    while (exp_addr_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (DRAIN_CYCLES) @(posedge clk);
    tests_run++;
    error_count += test_errors;
    if (test_errors == 0) begin
      $display("test %s: %0d stores checked, ok", name, stores_seen);
    end else begin
      tests_failed++;
      $display("test %s: %0d stores checked, %0d errors, FAIL", name, stores_seen,
               test_errors);
    end
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    arst_n     <= 1'b0;
    boot_addr  <= '0;
    instr_gnt  <= 1'b0;
    instr_rvalid <= 1'b0;
    instr_rdata  <= '0;
    data_gnt   <= 1'b0;
    cycle_count  = 0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;

    run_test("reset_state", MODE_NONE, 0, 3, 1, 3, 0);
    run_test("reg_alu_ops", MODE_REG, 0, 3, 1, 3, 1);
    run_test("imm_and_lui", MODE_IMM, 0, 3, 1, 3, 1);
    run_test("forwarding", MODE_DEP, 0, 3, 1, 3, 1);
    // Slow instruction side with long store stalls
    run_test("backpressure", MODE_MIX, 2, 3, 2, 3, 5);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
